/* hw/bp_pkg.sv */
package bp_pkg;

    // correction code reported to the core for the instruction in execute
    typedef enum logic [1:0] {
        FIX_NONE         = 2'd0, // prediction was right
        FIX_NOT_TAKEN    = 2'd1, // predicted taken, fell through
        FIX_TAKEN        = 2'd2, // predicted not taken, branched
        FIX_WRONG_TARGET = 2'd3  // taken as predicted but elsewhere
    } fix_e;

    // boot address 0x4000_0000, carried as pc[31:1]
    localparam logic [31:1] BOOT_TARGET = 31'h2000_0000;

endpackage

/* hw/bp_direction_table.sv */
`timescale 1ns/100ps

// gshare direction predictor
// 2-bit saturating counters indexed by pc xor global history
module bp_direction_table #(
    parameter int INDEX_W = 5
) (
    input  logic               clk_i,
    input  logic               rst_i,

    // prediction read, combinational
    input  logic [31:1]        pc_i,
    output logic               pred_taken_o,
    output logic [INDEX_W-1:0] pred_index_o,

    // resolved branch from execute
    input  logic               update_i,
    input  logic [INDEX_W-1:0] update_index_i,
    input  logic               update_taken_i
);

    localparam int DEPTH = 1 << INDEX_W;

    logic [1:0]         counters [DEPTH];
    logic [INDEX_W-1:0] history;   // outcomes of resolved branches, newest in bit 0

    logic [INDEX_W-1:0] rd_index;
    logic [1:0]         rd_cnt;

    logic [1:0]         upd_cnt;   // counter at the recorded index
    logic [1:0]         upd_next;  // after saturation

    // read side
    always_comb begin
        rd_index = pc_i[INDEX_W:1] ^ history;
        rd_cnt   = counters[rd_index];
    end

    assign pred_index_o = rd_index;
    assign pred_taken_o = rd_cnt[1]; // weakly or strongly taken

    // saturating step for the entry being trained
    always_comb begin
        upd_cnt = counters[update_index_i];
        if (update_taken_i) begin
            if (upd_cnt == 2'b11) begin
                upd_next = upd_cnt;
            end else begin
                upd_next = upd_cnt + 2'd1;
            end
        end else begin
            if (upd_cnt == 2'b00) begin
                upd_next = upd_cnt;
            end else begin
                upd_next = upd_cnt - 2'd1;
            end
        end
    end

    // counters and history only move when a branch resolves,
    // the index was captured at fetch so training hits the same entry
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                counters[i] <= 2'b00; // strongly not taken
            end
            history <= '0;
        end else if (update_i) begin
            counters[update_index_i] <= upd_next;
            history                  <= {history[INDEX_W-2:0], update_taken_i};
        end
    end

endmodule

/* hw/bp_target_buffer.sv */
`timescale 1ns/100ps

// direct-mapped branch target buffer, no tags
// aliasing PCs simply share an entry and retrain it
module bp_target_buffer #(
    parameter int INDEX_W = 5
) (
    input  logic        clk_i,
    input  logic        rst_i,

    // prediction read
    input  logic [31:1] pc_i,
    output logic [31:1] pred_target_o,

    // taken branch from execute
    input  logic        update_i,
    input  logic [31:1] update_pc_i,
    input  logic [31:1] update_target_i
);

    localparam int DEPTH = 1 << INDEX_W;

    logic [31:1]        targets [DEPTH];
    logic [INDEX_W-1:0] rd_index;
    logic [INDEX_W-1:0] wr_index;

    // halfword-aligned PC, so bit 1 is the lowest index bit
    assign rd_index = pc_i[INDEX_W:1];
    assign wr_index = update_pc_i[INDEX_W:1];

    assign pred_target_o = targets[rd_index];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // unknown branches point at the boot address
            for (int i = 0; i < DEPTH; i++) begin
                targets[i] <= bp_pkg::BOOT_TARGET;
            end
        end else if (update_i) begin
            targets[wr_index] <= update_target_i;
        end
    end

endmodule

/* hw/bp_resolve.sv */
`timescale 1ns/100ps

// tracks predictions through decode and execute, grades them against
// the execute outcome and trains both tables
module bp_resolve #(
    parameter int INDEX_W = 5
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,

    // fetch stage and the prediction made for it
    input  logic [31:1]        fetch_pc_i,
    input  logic               fetch_branch_i,
    input  logic               fetch_compressed_i,
    input  logic               pred_taken_i,
    input  logic [31:1]        pred_target_i,
    input  logic [INDEX_W-1:0] pred_index_i,

    // outcome from execute
    input  logic               exec_taken_i,
    input  logic [31:1]        exec_target_i,
    input  logic               exec_jump_i,

    // correction to the core
    output bp_pkg::fix_e       fix_o,
    output logic [31:1]        redirect_pc_o,

    // table training
    output logic               dir_update_o,
    output logic [INDEX_W-1:0] dir_index_o,
    output logic               dir_taken_o,
    output logic               tgt_update_o,
    output logic [31:1]        tgt_pc_o,
    output logic [31:1]        tgt_target_o
);

    // decode slot
    logic               dec_valid;
    logic [31:1]        dec_pc;
    logic               dec_comp;
    logic               dec_taken;
    logic [31:1]        dec_target;
    logic [INDEX_W-1:0] dec_index;

    // execute slot
    logic               exe_valid;
    logic [31:1]        exe_pc;
    logic               exe_comp;
    logic               exe_taken;
    logic [31:1]        exe_target;
    logic [INDEX_W-1:0] exe_index;

    logic               kill;      // flush younger entries on a correction
    logic               upd_ok;
    logic [31:1]        seq_pc;    // fall-through address

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_valid <= 1'b0;
            exe_valid <= 1'b0;
        end else if (!stall_i) begin
            dec_valid <= fetch_branch_i & ~kill;
            exe_valid <= dec_valid & ~kill;
        end
    end

    // payload just follows the valid bits
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_pc     <= fetch_pc_i;
            dec_comp   <= fetch_compressed_i;
            dec_taken  <= pred_taken_i;
            dec_target <= pred_target_i;
            dec_index  <= pred_index_i;

            exe_pc     <= dec_pc;
            exe_comp   <= dec_comp;
            exe_taken  <= dec_taken;
            exe_target <= dec_target;
            exe_index  <= dec_index;
        end
    end

    // compressed instruction is one halfword, else two
    assign seq_pc = exe_pc + (exe_comp ? 31'd1 : 31'd2);

    always_comb begin
        fix_o         = bp_pkg::FIX_NONE;
        redirect_pc_o = '0;
        if (exe_valid) begin
            if (exe_taken && !exec_taken_i) begin
                fix_o         = bp_pkg::FIX_NOT_TAKEN;
                redirect_pc_o = seq_pc;
            end else if (!exe_taken && exec_taken_i) begin
                fix_o         = bp_pkg::FIX_TAKEN;
                redirect_pc_o = exec_target_i;
            end else if (exe_taken && exec_target_i != exe_target) begin
                fix_o         = bp_pkg::FIX_WRONG_TARGET;
                redirect_pc_o = exec_target_i;
            end
        end
    end

    assign kill   = (fix_o != bp_pkg::FIX_NONE);
    assign upd_ok = exe_valid & ~stall_i; // a held entry trains only once

    // jumps are always taken, keep them out of the counters and history
    assign dir_update_o = upd_ok & ~exec_jump_i;
    assign dir_index_o  = exe_index;
    assign dir_taken_o  = exec_taken_i;

    assign tgt_update_o = upd_ok & exec_taken_i;
    assign tgt_pc_o     = exe_pc;
    assign tgt_target_o = exec_target_i;

endmodule

/* hw/branch_predictor.sv */
`timescale 1ns/100ps

// branch prediction unit, gshare direction plus btb
module branch_predictor #(
    parameter int INDEX_W = 5
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         stall_i,

    // fetch
    input  logic [31:1]  fetch_pc_i,
    input  logic         fetch_branch_i,
    input  logic         fetch_compressed_i,
    output logic         pred_taken_o,
    output logic [31:1]  pred_target_o,

    // execute
    input  logic         exec_taken_i,
    input  logic [31:1]  exec_target_i,
    input  logic         exec_jump_i,
    output bp_pkg::fix_e fix_o,
    output logic [31:1]  redirect_pc_o
);

    logic [INDEX_W-1:0] pred_index;

    logic               dir_update;
    logic [INDEX_W-1:0] dir_index;
    logic               dir_taken;

    logic               tgt_update;
    logic [31:1]        tgt_pc;
    logic [31:1]        tgt_target;

    bp_direction_table #(
        .INDEX_W (INDEX_W)
    ) u_dir (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .pc_i           (fetch_pc_i),
        .pred_taken_o   (pred_taken_o),
        .pred_index_o   (pred_index),
        .update_i       (dir_update),
        .update_index_i (dir_index),
        .update_taken_i (dir_taken)
    );

    bp_target_buffer #(
        .INDEX_W (INDEX_W)
    ) u_tgt (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .pc_i            (fetch_pc_i),
        .pred_target_o   (pred_target_o),
        .update_i        (tgt_update),
        .update_pc_i     (tgt_pc),
        .update_target_i (tgt_target)
    );

    bp_resolve #(
        .INDEX_W (INDEX_W)
    ) u_res (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .fetch_pc_i         (fetch_pc_i),
        .fetch_branch_i     (fetch_branch_i),
        .fetch_compressed_i (fetch_compressed_i),
        .pred_taken_i       (pred_taken_o),
        .pred_target_i      (pred_target_o),
        .pred_index_i       (pred_index),
        .exec_taken_i       (exec_taken_i),
        .exec_target_i      (exec_target_i),
        .exec_jump_i        (exec_jump_i),
        .fix_o              (fix_o),
        .redirect_pc_o      (redirect_pc_o),
        .dir_update_o       (dir_update),
        .dir_index_o        (dir_index),
        .dir_taken_o        (dir_taken),
        .tgt_update_o       (tgt_update),
        .tgt_pc_o           (tgt_pc),
        .tgt_target_o       (tgt_target)
    );

endmodule

/* verif/branch_predictor_chk.sv */
`timescale 1ns/100ps

// concurrent checks on the branch predictor top level
module branch_predictor_chk (
    input logic         clk_i,
    input logic         rst_i,
    input logic         stall_i,
    input bp_pkg::fix_e fix_i,
    input logic         dir_update_i,
    input logic         tgt_update_i
);

    // tracking slots are empty in reset and in the cycle after it
    a_reset_quiet: assert property (
        @(posedge clk_i) rst_i |=> (fix_i == bp_pkg::FIX_NONE) [*2]
    ) else $error("fix_o not FIX_NONE around reset");

    // a held execute entry must not train the tables
    a_stall_no_update: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stall_i |-> (!dir_update_i && !tgt_update_i)
    ) else $error("table update strobe while stalled");

    // younger entries are flushed by a correction
    a_kill_followers: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (!stall_i && fix_i != bp_pkg::FIX_NONE) |=> (fix_i == bp_pkg::FIX_NONE)
    ) else $error("correction not followed by FIX_NONE");

endmodule

bind branch_predictor branch_predictor_chk u_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .fix_i        (fix_o),
    .dir_update_i (dir_update),
    .tgt_update_i (tgt_update)
);

/* verif/branch_predictor_tb.sv */
`timescale 1ns/100ps

module branch_predictor_tb;

    localparam int IW    = 5;
    localparam int DEPTH = 1 << IW;

    // byte addresses carried as bits 31:1
    localparam logic [31:1] PC_A = 31'(32'h8000_0040 >> 1);
    localparam logic [31:1] PC_B = 31'(32'h8000_0108 >> 1);
    localparam logic [31:1] PC_C = 31'(32'h8000_0124 >> 1);
    localparam logic [31:1] PC_D = 31'(32'h8000_0132 >> 1);
    localparam logic [31:1] PC_J = 31'(32'h8000_0210 >> 1);
    localparam logic [31:1] T_1  = 31'(32'h8000_1000 >> 1);
    localparam logic [31:1] T_2  = 31'(32'h8000_1800 >> 1);
    localparam logic [31:1] T_B  = 31'(32'h8000_2000 >> 1);
    localparam logic [31:1] T_J  = 31'(32'h8000_3000 >> 1);

    logic         clk_i = 1'b0;
    logic         rst_i;
    logic         stall_i;
    logic [31:1]  fetch_pc_i;
    logic         fetch_branch_i;
    logic         fetch_compressed_i;
    logic         exec_taken_i;
    logic [31:1]  exec_target_i;
    logic         exec_jump_i;
    logic         pred_taken_o;
    logic [31:1]  pred_target_o;
    bp_pkg::fix_e fix_o;
    logic [31:1]  redirect_pc_o;

    // reference model state with slot 0 as decode and slot 1 as execute
    logic [1:0]    m_cnt [DEPTH];
    logic [IW-1:0] m_hist;
    logic [31:1]   m_tgt [DEPTH];
    logic          m_valid [2];
    logic [31:1]   m_pc [2];
    logic          m_comp [2];
    logic          m_ptaken [2];
    logic [31:1]   m_ptarget [2];
    logic [IW-1:0] m_idx [2];

    bp_pkg::fix_e exp_fix;
    logic [31:1]  exp_redirect;
    logic         exp_taken;
    logic [31:1]  exp_target;

    logic [31:0]  lfsr;
    logic         r_br;
    logic         r_comp;
    logic         r_stall;
    logic         r_taken;
    logic         r_jump;
    logic [2:0]   r_pc;
    logic [1:0]   r_tgt;

    branch_predictor #(
        .INDEX_W (IW)
    ) u_dut (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .fetch_pc_i         (fetch_pc_i),
        .fetch_branch_i     (fetch_branch_i),
        .fetch_compressed_i (fetch_compressed_i),
        .pred_taken_o       (pred_taken_o),
        .pred_target_o      (pred_target_o),
        .exec_taken_i       (exec_taken_i),
        .exec_target_i      (exec_target_i),
        .exec_jump_i        (exec_jump_i),
        .fix_o              (fix_o),
        .redirect_pc_o      (redirect_pc_o)
    );

    always #2 clk_i = ~clk_i;

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // small pc set where several pairs share table entries
    function automatic logic [31:1] pick_pc(input logic [2:0] sel);
        logic [31:0] byte_pc;
        case (sel)
            3'd0:    byte_pc = 32'h8000_0400;
            3'd1:    byte_pc = 32'h8000_0402;
            3'd2:    byte_pc = 32'h8000_0440; // aliases 0x400
            3'd3:    byte_pc = 32'h8000_0446;
            3'd4:    byte_pc = 32'h8000_050c;
            3'd5:    byte_pc = 32'h8000_054c; // aliases 0x50c
            3'd6:    byte_pc = 32'h8000_0612;
            default: byte_pc = 32'h8000_061e;
        endcase
        return byte_pc[31:1];
    endfunction

    function automatic logic [31:1] pick_target(input logic [1:0] sel);
        logic [31:0] byte_pc;
        case (sel)
            2'd0:    byte_pc = 32'h8000_4000;
            2'd1:    byte_pc = 32'h8000_4100;
            2'd2:    byte_pc = 32'h8000_4202;
            default: byte_pc = 32'h8000_4306;
        endcase
        return byte_pc[31:1];
    endfunction

    // fall-through computed in bytes and returned in halfword units
    function automatic logic [31:1] next_pc(input logic [31:1] pc, input logic comp);
        logic [31:0] byte_pc;
        byte_pc = {pc, 1'b0} + (comp ? 32'd2 : 32'd4);
        return byte_pc[31:1];
    endfunction

    // one cycle of the reference giving outputs for now and state after the coming edge
    function automatic void model_step(
        input  logic         rst,
        input  logic         stall,
        input  logic         br,
        input  logic         comp,
        input  logic [31:1]  pc,
        input  logic         ex_taken,
        input  logic [31:1]  ex_target,
        input  logic         jump,
        output bp_pkg::fix_e fix,
        output logic [31:1]  redir,
        output logic         ptaken,
        output logic [31:1]  ptarget
    );
        logic [IW-1:0] idx;
        logic          kill;
        idx     = pc[IW:1] ^ m_hist;
        ptaken  = (m_cnt[idx] >= 2'd2);
        ptarget = m_tgt[pc[IW:1]];
        fix     = bp_pkg::FIX_NONE;
        redir   = '0;
        if (m_valid[1] && m_ptaken[1] != ex_taken) begin
            fix   = ex_taken ? bp_pkg::FIX_TAKEN : bp_pkg::FIX_NOT_TAKEN;
            redir = ex_taken ? ex_target : next_pc(m_pc[1], m_comp[1]);
        end else if (m_valid[1] && ex_taken && m_ptarget[1] != ex_target) begin
            fix   = bp_pkg::FIX_WRONG_TARGET;
            redir = ex_target;
        end
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                m_cnt[i] = 2'd0;
                m_tgt[i] = bp_pkg::BOOT_TARGET;
            end
            m_hist     = '0;
            m_valid[0] = 1'b0;
            m_valid[1] = 1'b0;
        end else if (!stall) begin
            if (m_valid[1] && !jump) begin
                if (ex_taken && m_cnt[m_idx[1]] != 2'd3) begin
                    m_cnt[m_idx[1]] = m_cnt[m_idx[1]] + 2'd1;
                end else if (!ex_taken && m_cnt[m_idx[1]] != 2'd0) begin
                    m_cnt[m_idx[1]] = m_cnt[m_idx[1]] - 2'd1;
                end
                m_hist = {m_hist[IW-2:0], ex_taken};
            end
            if (m_valid[1] && ex_taken) begin
                m_tgt[m_pc[1][IW:1]] = ex_target;
            end
            kill         = (fix != bp_pkg::FIX_NONE);
            m_valid[1]   = m_valid[0] && !kill;
            m_pc[1]      = m_pc[0];
            m_comp[1]    = m_comp[0];
            m_ptaken[1]  = m_ptaken[0];
            m_ptarget[1] = m_ptarget[0];
            m_idx[1]     = m_idx[0];
            m_valid[0]   = br && !kill;
            m_pc[0]      = pc;
            m_comp[0]    = comp;
            m_ptaken[0]  = ptaken;
            m_ptarget[0] = ptarget;
            m_idx[0]     = idx;
        end
    endfunction

    task automatic check_fix(input string name, input bp_pkg::fix_e exp, input bp_pkg::fix_e act);
        if (act !== exp) begin
            $display("ERR %s expected %s actual %s (%b)", name, exp.name(), act.name(), act);
            $display("SIMULATION FAILED");
            $fatal(1, "fix mismatch in %s", name);
        end
    endtask

    task automatic check_pc(input string name, input logic [31:1] exp, input logic [31:1] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, {exp, 1'b0}, {act, 1'b0});
            $display("SIMULATION FAILED");
            $fatal(1, "pc mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "bit mismatch in %s", name);
        end
    endtask

    // samples mid-cycle after the 1 ns input update settled
    always @(negedge clk_i) begin
        model_step(rst_i, stall_i, fetch_branch_i, fetch_compressed_i, fetch_pc_i,
                   exec_taken_i, exec_target_i, exec_jump_i,
                   exp_fix, exp_redirect, exp_taken, exp_target);
        if (!rst_i) begin
            check_fix("model fix_o", exp_fix, fix_o);
            check_pc("model redirect_pc_o", exp_redirect, redirect_pc_o);
            check_bit("model pred_taken_o", exp_taken, pred_taken_o);
            check_pc("model pred_target_o", exp_target, pred_target_o);
        end
    end

    task automatic drive_cycle(input logic br, input logic [31:1] pc, input logic comp,
                               input logic stall);
        @(posedge clk_i);
        #1;
        fetch_branch_i     = br;
        fetch_pc_i         = pc;
        fetch_compressed_i = comp;
        stall_i            = stall;
    endtask

    task automatic set_outcome(input logic taken, input logic [31:1] target, input logic jump);
        exec_taken_i  = taken;
        exec_target_i = target;
        exec_jump_i   = jump;
    endtask

    // watch a few cycles for the correction of the entry in flight
    task automatic await_fix(input string name, input bp_pkg::fix_e want,
                             input logic [31:1] want_pc);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            if (fix_o !== bp_pkg::FIX_NONE) begin
                seen = 1'b1;
                break;
            end
        end
        if (want == bp_pkg::FIX_NONE) begin
            check_fix(name, want, fix_o);
        end else if (!seen) begin
            $display("%s timed out waiting for a correction on fix_o", name);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout in %s", name);
        end else begin
            check_fix(name, want, fix_o);
            check_pc(name, want_pc, redirect_pc_o);
        end
    endtask

    task automatic run_branch(input string name, input logic [31:1] pc, input logic comp,
                              input logic taken, input logic [31:1] target, input logic jump,
                              input bp_pkg::fix_e want);
        logic [31:1] want_pc;
        want_pc = (want == bp_pkg::FIX_NOT_TAKEN) ? next_pc(pc, comp) :
                  (want == bp_pkg::FIX_NONE) ? '0 : target;
        drive_cycle(1'b1, pc, comp, 1'b0);
        set_outcome(taken, target, jump);
        drive_cycle(1'b0, pc, comp, 1'b0);
        await_fix(name, want, want_pc);
    endtask

    task automatic present_pc(input logic [31:1] pc);
        drive_cycle(1'b0, pc, 1'b0, 1'b0);
        @(negedge clk_i);
    endtask

    initial begin
        rst_i              = 1'b1;
        stall_i            = 1'b0;
        fetch_pc_i         = '0;
        fetch_branch_i     = 1'b0;
        fetch_compressed_i = 1'b0;
        set_outcome(1'b0, '0, 1'b0);
        lfsr               = 32'hf3fb_db7b;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // cold tables
        for (int k = 0; k < 8; k++) begin
            present_pc(pick_pc(k[2:0]));
            check_bit("reset pred_taken", 1'b0, pred_taken_o);
            check_pc("reset pred_target", bp_pkg::BOOT_TARGET, pred_target_o);
            check_fix("reset fix", bp_pkg::FIX_NONE, fix_o);
        end

        // history fills with ones and the last two hit the same counter
        repeat (7) run_branch("cold taken", PC_A, 1'b0, 1'b1, T_1, 1'b0, bp_pkg::FIX_TAKEN);
        present_pc(PC_A);
        check_bit("learned taken", 1'b1, pred_taken_o);
        check_pc("learned target", T_1, pred_target_o);

        run_branch("wrong target", PC_A, 1'b0, 1'b1, T_2, 1'b0, bp_pkg::FIX_WRONG_TARGET);
        present_pc(PC_A);
        check_pc("retrained target", T_2, pred_target_o);
        run_branch("correct taken", PC_A, 1'b0, 1'b1, T_2, 1'b0, bp_pkg::FIX_NONE);
        run_branch("not taken 32b", PC_A, 1'b0, 1'b0, T_2, 1'b0, bp_pkg::FIX_NOT_TAKEN);
        // walk the history back to all ones
        repeat (5) run_branch("rewalk", PC_A, 1'b0, 1'b1, T_2, 1'b0, bp_pkg::FIX_TAKEN);
        run_branch("not taken 16b", PC_A, 1'b1, 1'b0, T_2, 1'b0, bp_pkg::FIX_NOT_TAKEN);

        // B corrects while held in execute, D and C behind it
        drive_cycle(1'b1, PC_B, 1'b0, 1'b0);
        set_outcome(1'b1, T_B, 1'b0);
        drive_cycle(1'b1, PC_D, 1'b0, 1'b0);
        drive_cycle(1'b1, PC_C, 1'b1, 1'b1);
        await_fix("stalled fix", bp_pkg::FIX_TAKEN, T_B);
        repeat (4) begin
            @(negedge clk_i);
            check_fix("stall holds fix", bp_pkg::FIX_TAKEN, fix_o);
            check_pc("stall holds redirect", T_B, redirect_pc_o);
            check_bit("stall holds prediction", 1'b0, pred_taken_o); // untrained counter for C
        end
        drive_cycle(1'b1, PC_D, 1'b0, 1'b0); // release kills D and C
        drive_cycle(1'b0, PC_D, 1'b0, 1'b0);
        await_fix("killed followers", bp_pkg::FIX_NONE, '0);

        // jumps train the btb only
        present_pc(PC_C);
        check_bit("history before jumps", 1'b1, pred_taken_o); // C xor history hits a counter at 2
        run_branch("jump", PC_J, 1'b0, 1'b1, T_J, 1'b1, bp_pkg::FIX_TAKEN);
        run_branch("jump again", PC_J, 1'b0, 1'b1, T_J, 1'b1, bp_pkg::FIX_TAKEN);
        present_pc(PC_C);
        check_bit("jump keeps history", 1'b1, pred_taken_o);
        present_pc(PC_J);
        check_bit("jump keeps counters", 1'b0, pred_taken_o);
        check_pc("jump target", T_J, pred_target_o);

        // random mix checked by the model every cycle
        for (int n = 0; n < 600; n++) begin
            r_br    = 1'(take_bits(1));
            r_pc    = 3'(take_bits(3));
            r_comp  = 1'(take_bits(1));
            r_stall = (take_bits(3) == 0);
            r_taken = 1'(take_bits(1));
            r_tgt   = 2'(take_bits(2));
            r_jump  = (take_bits(2) == 0);
            drive_cycle(r_br, pick_pc(r_pc), r_comp, r_stall);
            set_outcome(r_taken | r_jump, pick_target(r_tgt), r_jump);
        end
        @(negedge clk_i);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* flist.f */
hw/bp_pkg.sv
hw/bp_direction_table.sv
hw/bp_target_buffer.sv
hw/bp_resolve.sv
hw/branch_predictor.sv
verif/branch_predictor_chk.sv
verif/branch_predictor_tb.sv
